// File: logic/apu_reg_pkg.sv
package apu_reg_pkg;

  // CPU window 0x4000 to 0x4017
  localparam logic [15:0] reg_base = 16'h4000;
  localparam int reg_count = 24;

  typedef logic [4:0] reg_index_t;
  typedef logic [reg_count-1:0][7:0] reg_array_t;

  typedef struct packed {
    logic [6:0]  linear_load_data;
    logic        length_halt;
    logic [10:0] timer_load_data;
    logic [4:0]  length_load_data;
  } triangle_t;

  // Bit order as in 0x4015
  typedef struct packed {
    logic dmc_en;
    logic noise_en;
    logic triangle_en;
    logic pulse2_en;
    logic pulse1_en;
  } status_t;

  typedef struct packed {
    logic mode;
    logic inhibit_interrupt;
  } frame_counter_t;

  localparam reg_index_t tri_linear_idx = 5'd8;
  localparam reg_index_t tri_timer_lo_idx = 5'd10;
  localparam reg_index_t tri_timer_hi_idx = 5'd11;
  localparam reg_index_t status_idx = 5'd21;
  localparam reg_index_t frame_idx = 5'd23;

  function automatic triangle_t get_triangle_signals(input reg_array_t regs);
    triangle_t result;
    result.linear_load_data = regs[tri_linear_idx][6:0];
    result.length_halt = regs[tri_linear_idx][7];
    result.timer_load_data = {regs[tri_timer_hi_idx][2:0], regs[tri_timer_lo_idx]};
    result.length_load_data = regs[tri_timer_hi_idx][7:3];
    return result;
  endfunction

  function automatic status_t get_status_signals(input reg_array_t regs);
    return status_t'(regs[status_idx][4:0]);
  endfunction

  function automatic frame_counter_t get_frame_counter_signals(input reg_array_t regs);
    return frame_counter_t'(regs[frame_idx][7:6]);
  endfunction

endpackage

// File: logic/apu_timing_pkg.sv
package apu_timing_pkg;

  // Frame sequencer boundaries in cpu_clk_en pulses
  localparam logic [14:0] step1 = 15'd3729;
  localparam logic [14:0] step2 = 15'd7457;
  localparam logic [14:0] step3 = 15'd11186;
  localparam logic [14:0] step4 = 15'd14915;
  localparam logic [14:0] step5 = 15'd18641;

  // Length counter load values, indexed by the 5-bit field of 0x400B
  localparam logic [7:0] length_table [32] = '{
    8'd10,  8'd254, 8'd20,  8'd2,
    8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,
    8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,
    8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,
    8'd16,  8'd28,  8'd32,  8'd30
  };

  function automatic logic [7:0] length_lookup(input logic [4:0] index);
    return length_table[index];
  endfunction

  // Falling half then rising half
  function automatic logic [3:0] tri_sequence(input logic [4:0] step);
    if (step[4]) begin
      return step[3:0];
    end
    return ~step[3:0];
  endfunction

endpackage

// File: logic/triangle_ctrl_if.sv
`timescale 1ns/100ps

interface triangle_ctrl_if;
  import apu_reg_pkg::*;

  triangle_t fields;
  logic enable;
  logic linear_load;
  logic length_load;
  logic length_active;

  modport regs (
    output fields,
    output enable,
    output linear_load,
    output length_load,
    input  length_active
  );

  modport channel (
    input  fields,
    input  enable,
    input  linear_load,
    input  length_load,
    output length_active
  );

endinterface

// File: logic/mem_map_registers.sv
`timescale 1ns/100ps

module mem_map_registers (
  input  logic clk,
  input  logic rst,
  input  logic wb_cyc,
  input  logic wb_stb,
  input  logic wb_we,
  input  logic [15:0] wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic wb_ack,
  triangle_ctrl_if.regs tri_ctrl,
  output apu_reg_pkg::frame_counter_t frame_cfg,
  output logic frame_load,
  output logic irq_clear,
  input  logic irq
);
  import apu_reg_pkg::*;

  reg_array_t regs;
  logic [reg_count-1:0] reg_update;
  reg_index_t idx;
  logic in_window;
  logic request;
  logic status_read;
  status_t status;
  logic [7:0] status_byte;

  // A strobe counts once, the ack cycle masks it
  assign request = wb_cyc && wb_stb && !wb_ack;

  assign in_window = (wb_adr >= reg_base) && (wb_adr < reg_base + 16'(reg_count));
  assign idx = reg_index_t'(wb_adr - reg_base);
  assign status_read = request && !wb_we && in_window && (idx == status_idx);

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      irq_clear <= 1'b0;
      reg_update <= '0;
      regs <= '0;
    end else begin
      wb_ack <= request;
      irq_clear <= status_read;
      reg_update <= '0;
      // Writes outside the window are acked and dropped
      if (request && wb_we && in_window) begin
        regs[idx] <= wb_dat_w;
        reg_update[idx] <= 1'b1;
      end
    end
  end

  // Only the triangle and frame interrupt bits exist
  always_comb begin
    status_byte = 8'h00;
    status_byte[2] = tri_ctrl.length_active;
    status_byte[6] = irq;
  end

  always_ff @(posedge clk) begin
    wb_dat_r <= status_read ? status_byte : 8'h00;
  end

  assign status = get_status_signals(regs);

  assign tri_ctrl.fields = get_triangle_signals(regs);
  assign tri_ctrl.enable = status.triangle_en;
  // 0x4008 and 0x400B both arm the linear reload
  assign tri_ctrl.linear_load = reg_update[tri_linear_idx] | reg_update[tri_timer_hi_idx];
  assign tri_ctrl.length_load = reg_update[tri_timer_hi_idx];

  assign frame_cfg = get_frame_counter_signals(regs);
  assign frame_load = reg_update[frame_idx];

endmodule

// File: logic/frame_counter.sv
`timescale 1ns/100ps

module frame_counter (
  input  logic clk,
  input  logic rst,
  input  logic cpu_clk_en,
  input  apu_reg_pkg::frame_counter_t frame_cfg,
  input  logic frame_load,
  input  logic irq_clear,
  output logic quarter_clk_en,
  output logic half_clk_en,
  output logic irq
);
  import apu_timing_pkg::*;

  logic [14:0] count;
  logic at_step1;
  logic at_step2;
  logic at_step3;
  logic at_step4;
  logic at_step5;
  logic last_step;
  logic quarter_hit;
  logic half_hit;
  logic irq_hit;

  always_comb begin
    at_step1 = (count == step1);
    at_step2 = (count == step2);
    at_step3 = (count == step3);
    at_step4 = (count == step4);
    at_step5 = (count == step5);

    // Mode 1 runs one extra step before wrapping
    last_step = frame_cfg.mode ? (count >= step5) : (count >= step4);

    quarter_hit = cpu_clk_en && (at_step1 || at_step2 || at_step3 || at_step4 || at_step5);
    half_hit = cpu_clk_en && (at_step2 || (frame_cfg.mode ? at_step5 : at_step4));
    irq_hit = cpu_clk_en && at_step4 && !frame_cfg.mode &&
              !frame_cfg.inhibit_interrupt && !frame_load;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      quarter_clk_en <= 1'b0;
      half_clk_en <= 1'b0;
    end else begin
      quarter_clk_en <= 1'b0;
      half_clk_en <= 1'b0;
      if (frame_load) begin
        count <= '0;
        // Five-step mode clocks the units right away
        quarter_clk_en <= frame_cfg.mode;
        half_clk_en <= frame_cfg.mode;
      end else if (cpu_clk_en) begin
        count <= last_step ? 15'd0 : count + 15'd1;
        quarter_clk_en <= quarter_hit;
        half_clk_en <= half_hit;
      end
    end
  end

  // Interrupt flag, set at step4 of the four-step sequence
  always_ff @(posedge clk) begin
    if (rst) begin
      irq <= 1'b0;
    end else if (irq_hit) begin
      irq <= 1'b1;
    end else if (irq_clear || frame_cfg.inhibit_interrupt) begin
      irq <= 1'b0;
    end
  end

endmodule

// File: logic/triangle_channel.sv
`timescale 1ns/100ps

module triangle_channel (
  input  logic clk,
  input  logic rst,
  input  logic cpu_clk_en,
  input  logic quarter_clk_en,
  input  logic half_clk_en,
  triangle_ctrl_if.channel tri_ctrl,
  output logic [3:0] wave
);
  import apu_reg_pkg::*;
  import apu_timing_pkg::*;

  triangle_t fields;
  logic [10:0] timer;
  logic timer_zero;
  logic [6:0] linear_count;
  logic linear_reload;
  logic [7:0] length_count;
  logic [4:0] step;
  logic seq_advance;

  assign fields = tri_ctrl.fields;
  assign timer_zero = (timer == 11'd0);

  // Sequencer only moves while both gates are open
  assign seq_advance = cpu_clk_en && timer_zero &&
                       (linear_count != 7'd0) && (length_count != 8'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      timer <= '0;
    end else if (cpu_clk_en) begin
      if (timer_zero) begin
        timer <= fields.timer_load_data;
      end else begin
        timer <= timer - 11'd1;
      end
    end
  end

  // Reload flag is armed by register writes
  always_ff @(posedge clk) begin
    if (rst) begin
      linear_reload <= 1'b0;
    end else if (tri_ctrl.linear_load) begin
      linear_reload <= 1'b1;
    end else if (quarter_clk_en && !fields.length_halt) begin
      linear_reload <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      linear_count <= '0;
    end else if (quarter_clk_en) begin
      if (linear_reload) begin
        linear_count <= fields.linear_load_data;
      end else if (linear_count != 7'd0) begin
        linear_count <= linear_count - 7'd1;
      end
    end
  end

  // Disabled channel holds length at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      length_count <= '0;
    end else if (!tri_ctrl.enable) begin
      length_count <= '0;
    end else if (tri_ctrl.length_load) begin
      length_count <= length_lookup(fields.length_load_data);
    end else if (half_clk_en && !fields.length_halt && (length_count != 8'd0)) begin
      length_count <= length_count - 8'd1;
    end
  end

  assign tri_ctrl.length_active = (length_count != 8'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      step <= '0;
    end else if (seq_advance) begin
      step <= step + 5'd1;
    end
  end

  // Output lags the step by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      wave <= 4'd15;
    end else begin
      wave <= tri_sequence(step);
    end
  end

endmodule

// File: logic/apu.sv
`timescale 1ns/100ps

module apu (
  input  logic clk,
  input  logic rst,
  input  logic cpu_clk_en,
  input  logic wb_cyc,
  input  logic wb_stb,
  input  logic wb_we,
  input  logic [15:0] wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic wb_ack,
  output logic [3:0] wave,
  output logic irq
);
  import apu_reg_pkg::*;

  frame_counter_t frame_cfg;
  logic frame_load;
  logic irq_clear;
  logic quarter_clk_en;
  logic half_clk_en;

  triangle_ctrl_if tri_ctrl ();

  mem_map_registers mm_reg (
    .clk,
    .rst,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_w,
    .wb_dat_r,
    .wb_ack,
    .tri_ctrl(tri_ctrl.regs),
    .frame_cfg,
    .frame_load,
    .irq_clear,
    .irq
  );

  frame_counter fc (
    .clk,
    .rst,
    .cpu_clk_en,
    .frame_cfg,
    .frame_load,
    .irq_clear,
    .quarter_clk_en,
    .half_clk_en,
    .irq
  );

  triangle_channel tc (
    .clk,
    .rst,
    .cpu_clk_en,
    .quarter_clk_en,
    .half_clk_en,
    .tri_ctrl(tri_ctrl.channel),
    .wave
  );

endmodule

// File: include/apu_tb_model.svh
`ifndef APU_TB_MODEL_SVH
`define APU_TB_MODEL_SVH

// Frame boundaries in cycles, cpu_clk_en held high
localparam int ref_step2 = 7457;
localparam int ref_step4 = 14915;
localparam int ref_step5 = 18641;
localparam int ack_limit = 16;
localparam int wave_limit = 400;

localparam logic [7:0] ref_lengths [32] = '{
  10, 254, 20, 2, 40, 4, 80, 6, 160, 8, 60, 10, 14, 12, 26, 14,
  12, 16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30
};

// Table entries short enough to expire within a few frames
localparam logic [4:0] short_lengths [6] = '{3, 5, 7, 9, 0, 11};

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  return y ^ (y << 5);
endfunction

function automatic logic [31:0] next_random();
  rng_state = xorshift(rng_state);
  return rng_state;
endfunction

// Down from 15 to 0, then back up
function automatic logic [3:0] expected_level(input logic [4:0] step);
  if (step < 5'd16) begin
    return 4'(15 - int'(step));
  end
  return 4'(int'(step) - 16);
endfunction

function automatic logic [7:0] status_ref(input logic tri_active, input logic irq_flag);
  return {1'b0, irq_flag, 3'b000, tri_active, 2'b00};
endfunction

// Cycles from a four-step frame reload to the k-th half-frame pulse
function automatic int half_time(input int k);
  int frames;
  frames = (k - 1) / 2;
  return frames * (ref_step4 + 1) + ((k % 2 == 1) ? ref_step2 : ref_step4);
endfunction

task automatic bus_access(input logic we, input logic [15:0] addr,
                          input logic [7:0] wdata, output logic [7:0] rdata);
  int waited;
  @(posedge clk);
  wb_cyc <= 1'b1;
  wb_stb <= 1'b1;
  wb_we <= we;
  wb_adr <= addr;
  wb_dat_w <= wdata;
  waited = 0;
  do begin
    @(negedge clk);
    waited++;
  end while (wb_ack !== 1'b1 && waited < ack_limit);
  rdata = wb_dat_r;
  if (wb_ack !== 1'b1) begin
    $display("No ack from the DUT for address 0x%04h", addr);
    errors++;
  end
  @(posedge clk);
  wb_cyc <= 1'b0;
  wb_stb <= 1'b0;
  wb_we <= 1'b0;
  @(negedge clk);
  if (wb_ack !== 1'b0) begin
    $display("FAILED %0t: ack high for more than one cycle", $time);
    errors++;
  end
endtask

task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
  logic [7:0] ignored;
  bus_access(1'b1, addr, data, ignored);
endtask

task automatic read_expect(input logic [15:0] addr, input logic [7:0] expected);
  logic [7:0] data;
  bus_access(1'b0, addr, 8'h00, data);
  if (data !== expected) begin
    $display("FAILED %0t: read of 0x%04h gave 0x%02h, expected 0x%02h",
             $time, addr, data, expected);
    errors++;
  end
endtask

task automatic skip_cycles(input int n);
  repeat (n) @(negedge clk);
endtask

task automatic wait_wave_change(output int gap);
  gap = 0;
  while (wave === last_wave && gap < wave_limit) begin
    @(negedge clk);
    gap++;
  end
  if (wave === last_wave) begin
    $display("Wave did not change within %0d cycles", gap);
    errors++;
  end
  last_wave = wave;
endtask

// Levels repeat at both turnarounds, so one visible change may cover two steps
task automatic check_step(input int gap, input int period, input logic timed);
  logic [4:0] next_step;
  int advances;
  next_step = model_step + 5'd1;
  advances = 1;
  if (expected_level(next_step) == expected_level(model_step)) begin
    next_step = next_step + 5'd1;
    advances = 2;
  end
  if (last_wave !== expected_level(next_step)) begin
    $display("FAILED %0t: wave %0d, expected %0d", $time, last_wave,
             expected_level(next_step));
    errors++;
  end
  if (timed && gap != advances * (period + 1)) begin
    $display("FAILED %0t: wave changed after %0d cycles, expected %0d", $time, gap,
             advances * (period + 1));
    errors++;
  end
  model_step = next_step;
endtask

`endif

// File: bench/apu_tb.sv
`timescale 1ns/100ps

module apu_tb;
  import apu_reg_pkg::*;
  import apu_timing_pkg::*;

  logic clk;
  logic rst;
  logic cpu_clk_en;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [15:0] wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic wb_ack;
  logic [3:0] wave;
  logic irq;

  int errors;
  int tests_run;
  int tests_failed;
  logic [31:0] rng_state;
  logic [3:0] last_wave;
  logic [4:0] model_step;

  `include "apu_tb_model.svh"

  apu apu_inst (
    .clk,
    .rst,
    .cpu_clk_en,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_w,
    .wb_dat_r,
    .wb_ack,
    .wave,
    .irq
  );

  always #50 clk = ~clk;

  task automatic report(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d failed checks", name, errors - errors_before);
    end
  endtask

  task automatic irq_stays_low(input int cycles);
    int high;
    high = 0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (irq !== 1'b0) begin
        high++;
      end
    end
    if (high != 0) begin
      $display("FAILED %0t: irq high for %0d cycles, expected low", $time, high);
      errors++;
    end
  endtask

  task automatic status_length_load();
    status_t enables;
    logic [31:0] r;
    int start;
    start = errors;
    // Four-step mode with the interrupt inhibited
    write_reg(16'h4017, 8'h40);
    for (int i = 0; i < 6; i++) begin
      r = next_random();
      enables = status_t'(r[4:0]);
      write_reg(16'h4015, {3'b000, enables});
      write_reg(16'h400b, {r[12:8], 3'b000});
      read_expect(16'h4015, status_ref(enables.triangle_en, 1'b0));
      write_reg(16'h4015, 8'h00);
      read_expect(16'h4015, status_ref(1'b0, 1'b0));
    end
    report("status and length load", start);
  endtask

  task automatic frame_interrupt();
    int start;
    int waited;
    start = errors;
    write_reg(16'h4017, 8'h00);
    waited = 0;
    while (irq !== 1'b1 && waited < ref_step4 + 16) begin
      @(negedge clk);
      waited++;
    end
    if (irq !== 1'b1) begin
      $display("Frame interrupt did not rise within %0d cycles", waited);
      errors++;
    end else if (waited < ref_step4) begin
      $display("FAILED %0t: irq rose after %0d cycles, expected about %0d",
               $time, waited, ref_step4 + 1);
      errors++;
    end
    read_expect(16'h4015, status_ref(1'b0, 1'b1));
    if (irq !== 1'b0) begin
      $display("FAILED %0t: irq still high after status read", $time);
      errors++;
    end
    write_reg(16'h4017, 8'h40);
    irq_stays_low(2 * (ref_step4 + 1));
    // Five-step mode never raises the interrupt
    write_reg(16'h4017, 8'h80);
    irq_stays_low(2 * (ref_step5 + 1));
    report("frame interrupt", start);
  endtask

  task automatic triangle_stepping();
    logic [31:0] r;
    int start;
    int period;
    int gap;
    start = errors;
    if (wave !== expected_level(model_step)) begin
      $display("FAILED %0t: idle wave %0d, expected %0d", $time, wave,
               expected_level(model_step));
      errors++;
    end
    r = next_random();
    period = 12 + int'(r[15:0] % 52);
    write_reg(16'h4017, 8'h40);
    write_reg(16'h4015, 8'h04);
    write_reg(16'h4008, {1'b1, 7'(1 + r[23:16] % 127)});
    write_reg(16'h400a, 8'(period));
    write_reg(16'h400b, {r[28:24], 3'b000});
    // Five-step load clocks the linear counter at once
    write_reg(16'h4017, 8'hc0);
    last_wave = wave;
    for (int p = 0; p < 4; p++) begin
      if (p > 0) begin
        r = next_random();
        period = 12 + int'(r[15:0] % 52);
        write_reg(16'h400a, 8'(period));
        write_reg(16'h400b, {r[28:24], 3'b000});
      end
      // First change follows an unknown timer phase
      wait_wave_change(gap);
      check_step(gap, period, 1'b0);
      for (int k = 0; k < 6; k++) begin
        wait_wave_change(gap);
        check_step(gap, period, 1'b1);
      end
    end
    report("triangle stepping", start);
  endtask

  task automatic length_expiry();
    logic [31:0] r;
    logic [4:0] idx;
    int start;
    int changes;
    start = errors;
    r = next_random();
    idx = short_lengths[r[7:0] % 6];
    write_reg(16'h4017, 8'h40);
    // Linear counter outlasts the length counter
    write_reg(16'h4008, {1'b0, 7'(64 + r[15:8] % 64)});
    write_reg(16'h400b, {idx, 3'b000});
    // Frame restart so half-frames count from here
    write_reg(16'h4017, 8'h40);
    skip_cycles(half_time(int'(ref_lengths[idx])) - 40);
    read_expect(16'h4015, status_ref(1'b1, 1'b0));
    skip_cycles(80);
    read_expect(16'h4015, status_ref(1'b0, 1'b0));
    last_wave = wave;
    changes = 0;
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      if (wave !== last_wave) begin
        changes++;
      end
    end
    if (changes != 0) begin
      $display("FAILED %0t: wave still changing after length expiry", $time);
      errors++;
    end
    report("length expiry", start);
  endtask

  task automatic unmapped_access();
    logic [31:0] r;
    logic [15:0] addr;
    int start;
    int waited;
    start = errors;
    for (int i = 0; i < 12; i++) begin
      r = next_random();
      addr = r[16] ? 16'h4000 + r[15:0] % 24 : r[15:0];
      if (addr == 16'h4015) begin
        addr = 16'h4014;
      end
      read_expect(addr, 8'h00);
    end
    // Pending interrupt and a held length give a known status
    write_reg(16'h4015, 8'h04);
    write_reg(16'h4008, 8'hff);
    write_reg(16'h400b, 8'h08);
    write_reg(16'h4017, 8'h00);
    waited = 0;
    while (irq !== 1'b1 && waited < ref_step4 + 16) begin
      @(negedge clk);
      waited++;
    end
    if (irq !== 1'b1) begin
      $display("Frame interrupt did not rise before the writes outside the window");
      errors++;
    end
    for (int i = 0; i < 12; i++) begin
      r = next_random();
      addr = r[15:0];
      if (addr >= 16'h4000 && addr < 16'h4018) begin
        addr = addr ^ 16'h8000;
      end
      write_reg(addr, r[23:16]);
    end
    if (irq !== 1'b1) begin
      $display("FAILED %0t: irq changed by writes outside the window", $time);
      errors++;
    end
    read_expect(16'h4015, status_ref(1'b1, 1'b1));
    report("unmapped and write-only reads", start);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    cpu_clk_en = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 16'h0000;
    wb_dat_w = 8'h00;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rng_state = 32'h210b_368f;
    model_step = 5'd0;
    last_wave = 4'd15;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    status_length_load();
    frame_interrupt();
    triangle_stepping();
    length_expiry();
    unmapped_access();
    $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
logic/apu_reg_pkg.sv
logic/apu_timing_pkg.sv
logic/triangle_ctrl_if.sv
logic/mem_map_registers.sv
logic/frame_counter.sv
logic/triangle_channel.sv
logic/apu.sv
bench/apu_tb.sv
